// ==== bench/sample_discriminator_props.sv ====
////////////////////////////////////////
// bus and stream timing properties
////////////////////////////////////////

`timescale 1ns/1ns

module sample_discriminator_props (
  input logic adc_clk,
  input logic rst_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o,
  input logic adc_data_valid_o   [disc_pkg::CHANNELS],
  input logic adc_tstamp_valid_o [disc_pkg::CHANNELS]
);

  import disc_pkg::*;

  // ack lasts one cycle and answers a request
  ack_single: assert property (@(posedge adc_clk) disable iff (rst_i)
    wb_ack_o |=> !wb_ack_o)
    else $error("wishbone ack held longer than one cycle");

  ack_after_req: assert property (@(posedge adc_clk) disable iff (rst_i)
    wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
    else $error("wishbone ack without a preceding cyc and stb");

  ack_quiet: assert property (@(posedge adc_clk) rst_i |=> !wb_ack_o)
    else $error("wishbone ack high after reset");

  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_ch
    tstamp_with_data: assert property (@(posedge adc_clk) disable iff (rst_i)
      adc_tstamp_valid_o[ch] |-> adc_data_valid_o[ch])
      else $error("timestamp valid without data valid");

    stream_quiet: assert property (@(posedge adc_clk)
      rst_i |=> !adc_data_valid_o[ch] && !adc_tstamp_valid_o[ch])
      else $error("stream valid high after reset");
  end

endmodule

bind sample_discriminator sample_discriminator_props props0 (.*);

// ==== bench/sample_discriminator_tb.sv ====
////////////////////////////////////////
// sample discriminator testbench
// random stream checked against a model
////////////////////////////////////////

`timescale 1ns/1ns

module sample_discriminator_tb;

  import disc_pkg::*;
  import disc_regs_pkg::*;

  localparam int ROUNDS      = 12;
  localparam int STEPS       = 300;
  localparam int WATCHDOG_NS = ROUNDS * (STEPS + 120) * 10 * 2;

  logic     adc_clk;
  logic     rst;
  logic     reset_state;
  logic     wb_cyc, wb_stb, wb_we;
  wb_addr_t wb_adr;
  wb_data_t wb_wdat;
  wb_data_t wb_rdat;
  logic     wb_ack;
  sample_t  adc_data         [CHANNELS];
  logic     adc_valid        [CHANNELS];
  sample_t  out_data         [CHANNELS];
  logic     out_valid        [CHANNELS];
  tstamp_t  out_tstamp       [CHANNELS];
  logic     out_tstamp_valid [CHANNELS];

  integer seed = 32'h6002c41a;

  // configuration as written
  sample_t lo_m    [CHANNELS];
  sample_t hi_m    [CHANNELS];
  int      start_m [CHANNELS];
  int      stop_m  [CHANNELS];
  bit      dis_m   [CHANNELS];
  int      sel_m   [CHANNELS];
  // reference model state
  bit      trig_m     [CHANNELS];
  bit      hi_seen    [CHANNELS];
  int      last_hi    [CHANNELS];
  bit      open_prev  [CHANNELS];
  int      step_m     [CHANNELS];
  sample_t hist       [CHANNELS][$];
  sample_t exp_data   [CHANNELS][$];
  bit      exp_first  [CHANNELS][$];
  tstamp_t exp_ts     [CHANNELS][$];
  int      mode       [CHANNELS];
  int      burst_left [CHANNELS];

  sample_discriminator dut0 (
    .adc_clk            (adc_clk),
    .rst_i              (rst),
    .adc_reset_state_i  (reset_state),
    .wb_cyc_i           (wb_cyc),
    .wb_stb_i           (wb_stb),
    .wb_we_i            (wb_we),
    .wb_adr_i           (wb_adr),
    .wb_dat_i           (wb_wdat),
    .wb_dat_o           (wb_rdat),
    .wb_ack_o           (wb_ack),
    .adc_data_i         (adc_data),
    .adc_valid_i        (adc_valid),
    .adc_data_o         (out_data),
    .adc_data_valid_o   (out_valid),
    .adc_tstamp_o       (out_tstamp),
    .adc_tstamp_valid_o (out_tstamp_valid)
  );

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the last round finished");
    abort_run();
  end

  task automatic abort_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  function automatic int rand_below(int n);
    return ($random(seed) & 32'h7fffffff) % n;
  endfunction

  // bursts below, between or above the thresholds, or anywhere
  function automatic sample_t next_sample(int ch);
    int v;
    if (burst_left[ch] == 0) begin
      mode[ch] = rand_below(4);
      burst_left[ch] = 8 + rand_below(32);
    end
    burst_left[ch]--;
    case (mode[ch])
      0: v = lo_m[ch] - 1 - rand_below(1024);
      1: v = lo_m[ch] + rand_below(hi_m[ch] - lo_m[ch] + 1);
      2: v = hi_m[ch] + 1 + rand_below(1024);
      default: v = $random(seed);
    endcase
    return sample_t'(v);
  endfunction

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  task automatic model_cycle();
    bit open;
    if (reset_state) begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        trig_m[ch] = 1'b0;
        hi_seen[ch] = 1'b0;
        open_prev[ch] = 1'b0;
        step_m[ch] = 0;
      end
    end
    // all triggers first, a channel may follow the other one
    for (int ch = 0; ch < CHANNELS; ch++) begin
      if (adc_valid[ch]) begin
        hist[ch].push_back(adc_data[ch]);
        if (hist[ch].size() > 2 * MAX_DELAY_CYCLES) hist[ch].delete(0);
        if (adc_data[ch] > hi_m[ch]) trig_m[ch] = 1'b1;
        else if (adc_data[ch] < lo_m[ch]) trig_m[ch] = 1'b0;
      end
    end
    for (int ch = 0; ch < CHANNELS; ch++) begin
      if (adc_valid[ch]) begin
        if (trig_m[sel_m[ch]]) begin
          hi_seen[ch] = 1'b1;
          last_hi[ch] = step_m[ch];
        end
        open = hi_seen[ch] && (step_m[ch] - last_hi[ch] <= stop_m[ch]);
        if (dis_m[ch]) begin
          exp_data[ch].push_back(adc_data[ch]);
          exp_first[ch].push_back(1'b0);
        end else if (open) begin
          exp_data[ch].push_back(hist[ch][hist[ch].size() - 1 - start_m[ch]]);
          exp_first[ch].push_back(!open_prev[ch]);
          if (!open_prev[ch]) exp_ts[ch].push_back(tstamp_t'(step_m[ch]));
        end
        open_prev[ch] = open;
        step_m[ch]++;
      end
    end
  endtask

  always @(posedge adc_clk) begin
    if (!rst) model_cycle();
  end

  ////////////////////////////////////////
  // output monitor
  ////////////////////////////////////////

  task automatic check_channel(input int ch);
    sample_t exp_s;
    bit      first;
    tstamp_t exp_t;
    assert (!(out_tstamp_valid[ch] && !out_valid[ch])) else begin
      $display("timestamp without a sample on channel %0d at %0t", ch, $time);
      abort_run();
    end
    if (out_valid[ch]) begin
      assert (exp_data[ch].size() != 0) else begin
        $display("channel %0d emitted an unexpected sample at %0t", ch, $time);
        abort_run();
      end
      exp_s = exp_data[ch].pop_front();
      first = exp_first[ch].pop_front();
      assert (out_data[ch] == exp_s) else begin
        $display("MISMATCH at %0t: ch%0d sample expected %0d got %0d",
                 $time, ch, exp_s, out_data[ch]);
        abort_run();
      end
      assert (out_tstamp_valid[ch] == first) else begin
        $display("MISMATCH at %0t: ch%0d timestamp valid expected %0b got %0b",
                 $time, ch, first, out_tstamp_valid[ch]);
        abort_run();
      end
      if (first) begin
        exp_t = exp_ts[ch].pop_front();
        assert (out_tstamp[ch] == exp_t) else begin
          $display("MISMATCH at %0t: ch%0d timestamp expected %0d got %0d",
                   $time, ch, exp_t, out_tstamp[ch]);
          abort_run();
        end
      end
    end
  endtask

  always @(negedge adc_clk) begin
    if (!rst) begin
      for (int ch = 0; ch < CHANNELS; ch++) check_channel(ch);
    end
  end

  ////////////////////////////////////////
  // bus access and rounds
  ////////////////////////////////////////

  task automatic wb_access(input bit we, input wb_addr_t adr, input wb_data_t wdat,
                           output wb_data_t rdat);
    int waited;
    bit got_ack;
    @(posedge adc_clk);
    wb_cyc  <= 1'b1;
    wb_stb  <= 1'b1;
    wb_we   <= we;
    wb_adr  <= adr;
    wb_wdat <= wdat;
    got_ack = 1'b0;
    rdat = '0;
    for (waited = 0; waited < 8 && !got_ack; waited++) begin
      @(posedge adc_clk);
      if (wb_ack) begin
        got_ack = 1'b1;
        rdat = wb_rdat;
      end
    end
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
    assert (got_ack) else begin
      $display("no wishbone acknowledge by %0t", $time);
      abort_run();
    end
  endtask

  task automatic check_readback();
    wb_addr_t adr;
    wb_data_t wdat;
    wb_data_t rdat;
    wb_data_t mask;
    for (int i = 0; i < 8; i++) begin
      adr = wb_addr_t'(i % 4);
      wdat = $random(seed);
      mask = 32'hffffffff;
      if (adr == REG_DELAYS) mask = 32'h0000ffff;
      if (adr == REG_CTRL) mask = 32'h0000000f;
      wb_access(1'b1, adr, wdat, rdat);
      wb_access(1'b0, adr, '0, rdat);
      assert (rdat == (wdat & mask)) else begin
        $display("MISMATCH at %0t: register %0d read %h expected %h",
                 $time, adr, rdat, wdat & mask);
        abort_run();
      end
    end
  endtask

  task automatic configure(input bit [3:0] ctrl);
    wb_data_t word;
    wb_data_t unused;
    int       lo;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      lo = rand_below(8192) - 4000;
      lo_m[ch] = sample_t'(lo);
      hi_m[ch] = sample_t'(lo + rand_below(2048));
      word = {hi_m[ch], lo_m[ch]};
      wb_access(1'b1, (ch == 0) ? REG_THRESH0 : REG_THRESH1, word, unused);
    end
    word = $random(seed);
    wb_access(1'b1, REG_DELAYS, word, unused);
    wb_access(1'b1, REG_CTRL, {28'd0, ctrl}, unused);
    for (int ch = 0; ch < CHANNELS; ch++) begin
      start_m[ch] = word[8*ch +: 4];
      stop_m[ch]  = word[8*ch+4 +: 4];
      dis_m[ch]   = ctrl[ch];
      sel_m[ch]   = ctrl[2+ch];
    end
  endtask

  task automatic run_round(input bit [3:0] ctrl, input int density);
    int waited;
    configure(ctrl);
    @(posedge adc_clk);
    reset_state <= 1'b1;
    @(posedge adc_clk);
    reset_state <= 1'b0;
    for (int n = 0; n < STEPS; n++) begin
      @(posedge adc_clk);
      for (int ch = 0; ch < CHANNELS; ch++) begin
        adc_valid[ch] <= (rand_below(100) < density);
        adc_data[ch]  <= next_sample(ch);
      end
    end
    @(posedge adc_clk);
    for (int ch = 0; ch < CHANNELS; ch++) adc_valid[ch] <= 1'b0;
    // model has now seen the last step, wait for the pipeline to empty
    @(posedge adc_clk);
    for (waited = 0; waited < 16 && (exp_data[0].size() + exp_data[1].size()) != 0;
         waited++) begin
      @(posedge adc_clk);
    end
    assert ((exp_data[0].size() + exp_data[1].size()) == 0) else begin
      $display("expected samples never arrived by %0t", $time);
      abort_run();
    end
  endtask

  initial begin
    bit [3:0] ctrl;
    rst = 1'b1;
    reset_state = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_wdat = '0;
    for (int ch = 0; ch < CHANNELS; ch++) begin
      adc_data[ch] = '0;
      adc_valid[ch] = 1'b0;
    end
    repeat (5) @(posedge adc_clk);
    rst <= 1'b0;
    check_readback();
    // both channels bypassed at full rate, this also fills the buffers
    run_round(4'b0011, 100);
    // channel 1 gated by the trigger of channel 0
    run_round(4'b0000, 70);
    for (int r = 2; r < ROUNDS; r++) begin
      ctrl = 4'(rand_below(4) << 2);
      if (r % 4 == 3) ctrl = ctrl | 4'(rand_below(4));
      run_round(ctrl, 30 + rand_below(71));
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== build.f ====
design/disc_pkg.sv
design/disc_regs_pkg.sv
design/disc_regs.sv
design/trigger_hysteresis.sv
design/sample_delay_line.sv
design/discriminator_gate.sv
design/sample_discriminator.sv
bench/sample_discriminator_props.sv
bench/sample_discriminator_tb.sv

// ==== design/disc_pkg.sv ====
////////////////////////////////////////
// sample discriminator data path types
// sample, timestamp and delay widths
////////////////////////////////////////

package disc_pkg;

  ////////////////////////////////////////
  // channels and samples
  ////////////////////////////////////////

  // number of adc channels
  localparam int CHANNELS = 2;

  // signed adc sample
  localparam int SAMPLE_WIDTH = 16;
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

  ////////////////////////////////////////
  // timestamps
  ////////////////////////////////////////

  // count of valid steps since the last state reset
  localparam int TSTAMP_WIDTH = 32;
  typedef logic [TSTAMP_WIDTH-1:0] tstamp_t;

  ////////////////////////////////////////
  // delays
  ////////////////////////////////////////

  // delay line depth in samples
  localparam int MAX_DELAY_CYCLES = 16;

  // start and stop delays, counted in valid samples
  // the delay line pointers share this width
  localparam int DELAY_BITS = $clog2(MAX_DELAY_CYCLES);
  typedef logic [DELAY_BITS-1:0] delay_t;

endpackage

// ==== design/disc_regs.sv ====
////////////////////////////////////////
// wishbone classic register bank
// thresholds, delays, disable, trigger select
////////////////////////////////////////

`timescale 1ns/1ns

module disc_regs (
  input  logic                    adc_clk,
  input  logic                    rst_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  disc_regs_pkg::wb_addr_t wb_adr_i,
  input  disc_regs_pkg::wb_data_t wb_dat_i,
  output disc_regs_pkg::wb_data_t wb_dat_o,
  output logic                    wb_ack_o,
  output disc_pkg::sample_t       low_thresh_o  [disc_pkg::CHANNELS],
  output disc_pkg::sample_t       high_thresh_o [disc_pkg::CHANNELS],
  output disc_pkg::delay_t        start_delay_o [disc_pkg::CHANNELS],
  output disc_pkg::delay_t        stop_delay_o  [disc_pkg::CHANNELS],
  output logic                    disable_o     [disc_pkg::CHANNELS],
  output logic                    trig_sel_o    [disc_pkg::CHANNELS]
);

  import disc_pkg::*;
  import disc_regs_pkg::*;

  wb_state_t              state_q;
  wb_data_t               thresh_q [CHANNELS];
  logic [DELAYS_BITS-1:0] delays_q;
  logic [CTRL_BITS-1:0]   ctrl_q;

  ////////////////////////////////////////
  // bus handshake
  ////////////////////////////////////////

  // ack one cycle after cyc and stb, then back to idle
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      state_q <= WB_IDLE;
    end else begin
      case (state_q)
        WB_IDLE: if (wb_cyc_i && wb_stb_i) state_q <= WB_ACK;
        default: state_q <= WB_IDLE;
      endcase
    end
  end

  assign wb_ack_o = (state_q == WB_ACK);

  // writes land on the ack cycle
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      thresh_q[0] <= '0;
      thresh_q[1] <= '0;
      delays_q    <= '0;
      ctrl_q      <= '0;
    end else if (wb_ack_o && wb_we_i) begin
      case (wb_adr_i)
        REG_THRESH0: thresh_q[0] <= wb_dat_i;
        REG_THRESH1: thresh_q[1] <= wb_dat_i;
        REG_DELAYS:  delays_q    <= wb_dat_i[DELAYS_BITS-1:0];
        REG_CTRL:    ctrl_q      <= wb_dat_i[CTRL_BITS-1:0];
        default: ;
      endcase
    end
  end

  // read back, unused bits zero
  always_comb begin
    wb_dat_o = '0;
    case (wb_adr_i)
      REG_THRESH0: wb_dat_o = thresh_q[0];
      REG_THRESH1: wb_dat_o = thresh_q[1];
      REG_DELAYS:  wb_dat_o[DELAYS_BITS-1:0] = delays_q;
      REG_CTRL:    wb_dat_o[CTRL_BITS-1:0] = ctrl_q;
      default: ;
    endcase
  end

  ////////////////////////////////////////
  // field decode
  ////////////////////////////////////////

  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_fields
    assign low_thresh_o[ch]  = thresh_q[ch][SAMPLE_WIDTH-1:0];
    assign high_thresh_o[ch] = thresh_q[ch][2*SAMPLE_WIDTH-1:SAMPLE_WIDTH];
    // two nibbles per channel, start then stop
    assign start_delay_o[ch] = delays_q[2*ch*DELAY_BITS +: DELAY_BITS];
    assign stop_delay_o[ch]  = delays_q[(2*ch+1)*DELAY_BITS +: DELAY_BITS];
    assign disable_o[ch]     = ctrl_q[ch];
    assign trig_sel_o[ch]    = ctrl_q[CHANNELS+ch];
  end

endmodule

// ==== design/disc_regs_pkg.sv ====
////////////////////////////////////////
// register bank definitions
// wishbone widths, word map, bus states
////////////////////////////////////////

package disc_regs_pkg;

  // bus widths
  localparam int WB_ADDR_WIDTH = 2;
  localparam int WB_DATA_WIDTH = 32;
  typedef logic [WB_ADDR_WIDTH-1:0] wb_addr_t;
  typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;

  ////////////////////////////////////////
  // word addresses
  ////////////////////////////////////////

  // low threshold in 15:0, high threshold in 31:16
  localparam wb_addr_t REG_THRESH0 = 2'd0;
  localparam wb_addr_t REG_THRESH1 = 2'd1;
  // start/stop delay nibbles, channel 0 first
  localparam wb_addr_t REG_DELAYS  = 2'd2;
  // disable in 1:0, trigger select in 3:2
  localparam wb_addr_t REG_CTRL    = 2'd3;

  // stored bits of the delays and control words
  localparam int DELAYS_BITS = 16;
  localparam int CTRL_BITS   = 4;

  // single-cycle acknowledge
  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_t;

endpackage

// ==== design/discriminator_gate.sv ====
////////////////////////////////////////
// discriminator gate and timestamps
// trigger routing, stop-delay hold, output select
////////////////////////////////////////

`timescale 1ns/1ns

module discriminator_gate (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  logic              adc_reset_state_i,
  input  logic              trig_i             [disc_pkg::CHANNELS],
  input  logic              trig_valid_i       [disc_pkg::CHANNELS],
  input  disc_pkg::sample_t adc_data_i         [disc_pkg::CHANNELS],
  input  disc_pkg::sample_t delayed_data_i     [disc_pkg::CHANNELS],
  input  disc_pkg::delay_t  stop_delay_i       [disc_pkg::CHANNELS],
  input  logic              disable_i          [disc_pkg::CHANNELS],
  input  logic              trig_sel_i         [disc_pkg::CHANNELS],
  output disc_pkg::sample_t adc_data_o         [disc_pkg::CHANNELS],
  output logic              adc_data_valid_o   [disc_pkg::CHANNELS],
  output disc_pkg::tstamp_t adc_tstamp_o       [disc_pkg::CHANNELS],
  output logic              adc_tstamp_valid_o [disc_pkg::CHANNELS]
);

  import disc_pkg::*;

  // state reset delayed to line up with the trigger stage
  logic    reset_state_q;
  delay_t  hold_q   [CHANNELS];
  logic    gate_q   [CHANNELS];
  tstamp_t step_q   [CHANNELS];
  logic    sel_trig [CHANNELS];
  logic    gate     [CHANNELS];

  // gate is open on a selected trigger or while the hold runs down
  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      sel_trig[ch] = trig_i[trig_sel_i[ch]];
      gate[ch]     = sel_trig[ch] | (hold_q[ch] != '0);
    end
  end

  ////////////////////////////////////////
  // control state and valids
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      reset_state_q <= 1'b0;
      for (int ch = 0; ch < CHANNELS; ch++) begin
        hold_q[ch]             <= '0;
        gate_q[ch]             <= 1'b0;
        step_q[ch]             <= '0;
        adc_data_valid_o[ch]   <= 1'b0;
        adc_tstamp_valid_o[ch] <= 1'b0;
      end
    end else begin
      reset_state_q <= adc_reset_state_i;
      for (int ch = 0; ch < CHANNELS; ch++) begin
        adc_data_valid_o[ch]   <= 1'b0;
        adc_tstamp_valid_o[ch] <= 1'b0;
        if (reset_state_q) begin
          hold_q[ch] <= '0;
          gate_q[ch] <= 1'b0;
          step_q[ch] <= '0;
        end else if (trig_valid_i[ch]) begin
          // reload on trigger, otherwise count down to zero
          if (sel_trig[ch]) begin
            hold_q[ch] <= stop_delay_i[ch];
          end else if (hold_q[ch] != '0) begin
            hold_q[ch] <= hold_q[ch] - 1'b1;
          end
          gate_q[ch] <= gate[ch];
          step_q[ch] <= step_q[ch] + 1'b1;

          adc_data_valid_o[ch]   <= disable_i[ch] | gate[ch];
          // rising edge of the gate
          adc_tstamp_valid_o[ch] <= ~disable_i[ch] & gate[ch] & ~gate_q[ch];
        end
      end
    end
  end

  ////////////////////////////////////////
  // payload
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      if (trig_valid_i[ch]) begin
        // disabled channel passes the undelayed stream
        adc_data_o[ch]   <= disable_i[ch] ? adc_data_i[ch] : delayed_data_i[ch];
        adc_tstamp_o[ch] <= step_q[ch];
      end
    end
  end

endmodule

// ==== design/sample_delay_line.sv ====
////////////////////////////////////////
// start delay line
// circular buffer per channel, 16 deep
////////////////////////////////////////

`timescale 1ns/1ns

module sample_delay_line (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  disc_pkg::sample_t adc_data_i     [disc_pkg::CHANNELS],
  input  logic              adc_valid_i    [disc_pkg::CHANNELS],
  input  disc_pkg::delay_t  start_delay_i  [disc_pkg::CHANNELS],
  output disc_pkg::sample_t delayed_data_o [disc_pkg::CHANNELS]
);

  import disc_pkg::*;

  // write pointer, wraps over the full depth
  delay_t  wr_ptr_q [CHANNELS];
  delay_t  rd_ptr   [CHANNELS];
  sample_t mem_q    [CHANNELS][MAX_DELAY_CYCLES];

  ////////////////////////////////////////
  // pointers
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        wr_ptr_q[ch] <= '0;
      end
    end else begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        if (adc_valid_i[ch]) wr_ptr_q[ch] <= wr_ptr_q[ch] + 1'b1;
      end
    end
  end

  // the current step goes to wr_ptr, so step n-S sits S entries behind it
  always_comb begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      rd_ptr[ch] = wr_ptr_q[ch] - start_delay_i[ch];
    end
  end

  ////////////////////////////////////////
  // buffer and read port
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < CHANNELS; ch++) begin
      if (adc_valid_i[ch]) begin
        mem_q[ch][wr_ptr_q[ch]] <= adc_data_i[ch];
        // zero delay bypasses the buffer
        if (start_delay_i[ch] == '0) begin
          delayed_data_o[ch] <= adc_data_i[ch];
        end else begin
          delayed_data_o[ch] <= mem_q[ch][rd_ptr[ch]];
        end
      end
    end
  end

endmodule

// ==== design/sample_discriminator.sv ====
////////////////////////////////////////
// two-channel sample discriminator
////////////////////////////////////////

`timescale 1ns/1ns

module sample_discriminator (
  input  logic                    adc_clk,
  input  logic                    rst_i,
  input  logic                    adc_reset_state_i,
  // wishbone slave
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  disc_regs_pkg::wb_addr_t wb_adr_i,
  input  disc_regs_pkg::wb_data_t wb_dat_i,
  output disc_regs_pkg::wb_data_t wb_dat_o,
  output logic                    wb_ack_o,
  // adc stream in
  input  disc_pkg::sample_t       adc_data_i         [disc_pkg::CHANNELS],
  input  logic                    adc_valid_i        [disc_pkg::CHANNELS],
  // discriminated stream and timestamps out
  output disc_pkg::sample_t       adc_data_o         [disc_pkg::CHANNELS],
  output logic                    adc_data_valid_o   [disc_pkg::CHANNELS],
  output disc_pkg::tstamp_t       adc_tstamp_o       [disc_pkg::CHANNELS],
  output logic                    adc_tstamp_valid_o [disc_pkg::CHANNELS]
);

  import disc_pkg::*;

  sample_t low_thresh   [CHANNELS];
  sample_t high_thresh  [CHANNELS];
  delay_t  start_delay  [CHANNELS];
  delay_t  stop_delay   [CHANNELS];
  logic    disable_ch   [CHANNELS];
  logic    trig_sel     [CHANNELS];
  logic    trig         [CHANNELS];
  logic    trig_valid   [CHANNELS];
  sample_t delayed_data [CHANNELS];
  sample_t adc_data_q   [CHANNELS];

  // bypass path, one stage to match trigger and delay line
  always_ff @(posedge adc_clk) begin
    adc_data_q <= adc_data_i;
  end

  disc_regs regs0 (
    .adc_clk       (adc_clk),
    .rst_i         (rst_i),
    .wb_cyc_i      (wb_cyc_i),
    .wb_stb_i      (wb_stb_i),
    .wb_we_i       (wb_we_i),
    .wb_adr_i      (wb_adr_i),
    .wb_dat_i      (wb_dat_i),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_o      (wb_ack_o),
    .low_thresh_o  (low_thresh),
    .high_thresh_o (high_thresh),
    .start_delay_o (start_delay),
    .stop_delay_o  (stop_delay),
    .disable_o     (disable_ch),
    .trig_sel_o    (trig_sel)
  );

  trigger_hysteresis trig0 (
    .adc_clk           (adc_clk),
    .rst_i             (rst_i),
    .adc_reset_state_i (adc_reset_state_i),
    .adc_data_i        (adc_data_i),
    .adc_valid_i       (adc_valid_i),
    .low_thresh_i      (low_thresh),
    .high_thresh_i     (high_thresh),
    .trig_o            (trig),
    .trig_valid_o      (trig_valid)
  );

  sample_delay_line delay0 (
    .adc_clk        (adc_clk),
    .rst_i          (rst_i),
    .adc_data_i     (adc_data_i),
    .adc_valid_i    (adc_valid_i),
    .start_delay_i  (start_delay),
    .delayed_data_o (delayed_data)
  );

  discriminator_gate gate0 (
    .adc_clk            (adc_clk),
    .rst_i              (rst_i),
    .adc_reset_state_i  (adc_reset_state_i),
    .trig_i             (trig),
    .trig_valid_i       (trig_valid),
    .adc_data_i         (adc_data_q),
    .delayed_data_i     (delayed_data),
    .stop_delay_i       (stop_delay),
    .disable_i          (disable_ch),
    .trig_sel_i         (trig_sel),
    .adc_data_o         (adc_data_o),
    .adc_data_valid_o   (adc_data_valid_o),
    .adc_tstamp_o       (adc_tstamp_o),
    .adc_tstamp_valid_o (adc_tstamp_valid_o)
  );

endmodule

// ==== design/trigger_hysteresis.sv ====
////////////////////////////////////////
// analog trigger with hysteresis
// per-channel high/low threshold compare
////////////////////////////////////////

`timescale 1ns/1ns

module trigger_hysteresis (
  input  logic              adc_clk,
  input  logic              rst_i,
  input  logic              adc_reset_state_i,
  input  disc_pkg::sample_t adc_data_i    [disc_pkg::CHANNELS],
  input  logic              adc_valid_i   [disc_pkg::CHANNELS],
  input  disc_pkg::sample_t low_thresh_i  [disc_pkg::CHANNELS],
  input  disc_pkg::sample_t high_thresh_i [disc_pkg::CHANNELS],
  output logic              trig_o        [disc_pkg::CHANNELS],
  output logic              trig_valid_o  [disc_pkg::CHANNELS]
);

  import disc_pkg::*;

  // trig_o is the held state itself, one stage after the sample
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        trig_o[ch]       <= 1'b0;
        trig_valid_o[ch] <= 1'b0;
      end
    end else begin
      for (int ch = 0; ch < CHANNELS; ch++) begin
        // steps seen during a state reset are not counted downstream
        trig_valid_o[ch] <= adc_valid_i[ch] & ~adc_reset_state_i;

        if (adc_reset_state_i) begin
          trig_o[ch] <= 1'b0;
        end else if (adc_valid_i[ch]) begin
          // signed compares, state kept between the thresholds
          if (adc_data_i[ch] > high_thresh_i[ch]) begin
            trig_o[ch] <= 1'b1;
          end else if (adc_data_i[ch] < low_thresh_i[ch]) begin
            trig_o[ch] <= 1'b0;
          end
        end
      end
    end
  end

endmodule
